// File: src/mem_geom_pkg.sv
package mem_geom_pkg;

	// --------------------
	// Logical word geometry
	// --------------------

	// Full word as seen by the host and the output stream
	localparam int WORD_WIDTH = 16;

	// Number of logical words
	localparam int WORD_DEPTH = 32;

	// Logical address width
	localparam int WORD_ADDR_WIDTH = $clog2(WORD_DEPTH);

	// --------------------
	// Pumped storage geometry
	// --------------------

	// Storage is half as wide
	localparam int HALF_WIDTH = WORD_WIDTH / 2;

	// And twice as deep
	localparam int MEM_DEPTH = 2 * WORD_DEPTH;

	// One extra bit selects the half, LSB set for the high half
	localparam int MEM_ADDR_WIDTH = WORD_ADDR_WIDTH + 1;

endpackage

// File: src/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

	// Kind of half-word memory access
	typedef enum logic {
		CFG_READ,
		CFG_WRITE
	} cfg_op_e;

	// Configuration adapter sequencing
	typedef enum logic [2:0] {
		IDLE,        // waiting for cfg_req
		LOW,         // low half access
		HIGH,        // high half access
		WAIT_REPLY,  // read only, last reply beat pending
		ACK          // holding cfg_ack until cfg_req drops
	} adapter_state_e;

	// Stream read engine
	typedef enum logic {
		HALT,
		RUN
	} stream_state_e;

endpackage

// File: src/half_mem_if.sv
`timescale 1ns/1ps

interface half_mem_if;
	import mem_geom_pkg::*;
	import mem_ctrl_pkg::*;

	// Request side
	logic                      ce;
	cfg_op_e                   op;
	logic [MEM_ADDR_WIDTH-1:0] addr;
	logic [HALF_WIDTH-1:0]     wdata;

	// Memory side
	logic                      grant;
	logic                      rvalid;  // one cycle after a granted read
	logic [HALF_WIDTH-1:0]     rdata;

	// Adapter end
	modport requester (
		output ce, op, addr, wdata,
		input  grant, rvalid, rdata
	);

	// Streamer end
	modport memory (
		input  ce, op, addr, wdata,
		output grant, rvalid, rdata
	);

endinterface

// File: src/cfg_pump_adapter.sv
`timescale 1ns/1ps

module cfg_pump_adapter (
	input  logic                                 clk2x,
	input  logic                                 rst,
	input  logic                                 cfg_req,
	input  logic                                 cfg_we,
	input  logic [mem_geom_pkg::WORD_ADDR_WIDTH-1:0] cfg_addr,
	input  logic [mem_geom_pkg::WORD_WIDTH-1:0]  cfg_wdata,
	output logic                                 cfg_ack,
	output logic [mem_geom_pkg::WORD_WIDTH-1:0]  cfg_rdata,
	half_mem_if.requester                        mem
);
	import mem_geom_pkg::*;
	import mem_ctrl_pkg::*;

	adapter_state_e        state;
	logic [1:0]            beat_cnt;
	logic [1:0]            beat_next;
	logic                  hi_sel;
	logic [WORD_WIDTH-1:0] rdata_q;

	// --------------------
	// Half-word requests
	// --------------------

	// Host holds address and data for the whole handshake
	assign hi_sel = (state == HIGH);

	assign mem.ce = (state == LOW) || (state == HIGH);
	assign mem.op = cfg_we ? CFG_WRITE : CFG_READ;

	// Word address times two, plus one for the upper half
	assign mem.addr = {cfg_addr, hi_sel};

	// Low half goes out first
	assign mem.wdata = hi_sel ? cfg_wdata[WORD_WIDTH-1:HALF_WIDTH]
	                          : cfg_wdata[HALF_WIDTH-1:0];

	// Reply beats seen so far including this cycle
	assign beat_next = beat_cnt + {1'b0, mem.rvalid};

	// --------------------
	// Sequencer
	// --------------------

	always_ff @(posedge clk2x) begin
		if (rst) begin
			state <= IDLE;
			beat_cnt <= '0;
		end else begin
			beat_cnt <= beat_next;
			case (state)
				IDLE: begin
					// New request only after the previous return to zero
					if (cfg_req) begin
						state <= LOW;
						beat_cnt <= '0;
					end
				end
				LOW: begin
					if (mem.grant) begin
						state <= HIGH;
					end
				end
				HIGH: begin
					// Writes are done once the high half is taken
					if (mem.grant) begin
						state <= (mem.op == CFG_WRITE) ? ACK : WAIT_REPLY;
					end
				end
				WAIT_REPLY: begin
					if (beat_next == 2'd2) begin
						state <= ACK;
					end
				end
				ACK: begin
					if (!cfg_req) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// --------------------
	// Read reply assembly
	// --------------------

	// Shift in from the top, first beat ends up in the low half
	always_ff @(posedge clk2x) begin
		if (mem.rvalid) begin
			rdata_q <= {mem.rdata, rdata_q[WORD_WIDTH-1:HALF_WIDTH]};
		end
	end

	assign cfg_ack = (state == ACK);
	assign cfg_rdata = rdata_q;

endmodule

// File: src/half_word_streamer.sv
`timescale 1ns/1ps

module half_word_streamer (
	input  logic                            clk2x,
	input  logic                            rst,
	input  logic                            enable,
	input  logic                            half_ready,
	output logic                            half_valid,
	output logic [mem_geom_pkg::HALF_WIDTH-1:0] half_data,
	output logic                            flush,
	half_mem_if.memory                      mem
);
	import mem_geom_pkg::*;
	import mem_ctrl_pkg::*;

	// Half-width storage, no reset
	logic [HALF_WIDTH-1:0]     mem_q [MEM_DEPTH];
	logic [HALF_WIDTH-1:0]     rd_q;
	logic [MEM_ADDR_WIDTH-1:0] rd_addr;
	logic                      rd_en;

	stream_state_e             state;
	logic                      enable_q;
	logic [MEM_ADDR_WIDTH-1:0] ptr;
	logic                      issue;
	logic                      cfg_rd_q;   // reply in rd_q belongs to config
	logic                      strm_rd_q;  // reply in rd_q belongs to stream

	// Two-entry prefetch buffer
	logic [HALF_WIDTH-1:0]     buf_q [2];
	logic                      wr_idx;
	logic                      rd_idx;
	logic [1:0]                count;
	logic [1:0]                level;
	logic                      push;
	logic                      pop;
	logic                      slot_free;

	// --------------------
	// Arbitration
	// --------------------

	// Config always wins
	assign mem.grant = mem.ce;

	// Buffered plus in flight, a pop this cycle frees one slot
	assign level = count + {1'b0, strm_rd_q};
	assign pop = half_valid && half_ready;
	assign slot_free = (level < 2'd2) || pop;

	assign issue = (state == RUN) && enable && !mem.ce && slot_free;

	assign rd_en = (mem.ce && (mem.op == CFG_READ)) || issue;
	assign rd_addr = mem.ce ? mem.addr : ptr;

	// --------------------
	// Storage
	// --------------------

	always_ff @(posedge clk2x) begin
		if (mem.ce && (mem.op == CFG_WRITE)) begin
			mem_q[mem.addr] <= mem.wdata;
		end
		// Registered read port shared by both users
		if (rd_en) begin
			rd_q <= mem_q[rd_addr];
		end
	end

	// Tag who owns the next reply
	always_ff @(posedge clk2x) begin
		if (rst) begin
			cfg_rd_q <= 1'b0;
			strm_rd_q <= 1'b0;
		end else begin
			cfg_rd_q <= mem.ce && (mem.op == CFG_READ);
			strm_rd_q <= issue;
		end
	end

	assign mem.rvalid = cfg_rd_q;
	assign mem.rdata = rd_q;

	// --------------------
	// Stream control
	// --------------------

	always_ff @(posedge clk2x) begin
		if (rst) begin
			state <= HALT;
			enable_q <= 1'b0;
		end else begin
			enable_q <= enable;
			case (state)
				HALT: begin
					if (enable) begin
						state <= RUN;
					end
				end
				RUN: begin
					if (!enable) begin
						state <= HALT;
					end
				end
				default: begin
					state <= HALT;
				end
			endcase
		end
	end

	// Falling edge of enable
	assign flush = enable_q && !enable;

	// Wrapping half-word pointer, back to 0 while disabled
	always_ff @(posedge clk2x) begin
		if (rst || !enable) begin
			ptr <= '0;
		end else if (issue) begin
			if (ptr == MEM_ADDR_WIDTH'(MEM_DEPTH - 1)) begin
				ptr <= '0;
			end else begin
				ptr <= ptr + 1'b1;
			end
		end
	end

	// --------------------
	// Prefetch buffer
	// --------------------

	// Late replies after enable drops are discarded
	assign push = strm_rd_q && enable;

	always_ff @(posedge clk2x) begin
		if (rst || !enable) begin
			wr_idx <= 1'b0;
			rd_idx <= 1'b0;
			count <= '0;
		end else begin
			if (push) begin
				wr_idx <= !wr_idx;
			end
			if (pop) begin
				rd_idx <= !rd_idx;
			end
			count <= count + {1'b0, push} - {1'b0, pop};
		end
	end

	always_ff @(posedge clk2x) begin
		if (push) begin
			buf_q[wr_idx] <= rd_q;
		end
	end

	assign half_valid = (count != 2'd0);
	assign half_data = buf_q[rd_idx];

endmodule

// File: src/word_pair_assembler.sv
`timescale 1ns/1ps

module word_pair_assembler (
	input  logic                            clk2x,
	input  logic                            rst,
	input  logic                            flush,
	input  logic                            half_valid,
	input  logic [mem_geom_pkg::HALF_WIDTH-1:0] half_data,
	input  logic                            out_ready,
	output logic                            half_ready,
	output logic                            out_valid,
	output logic [mem_geom_pkg::WORD_WIDTH-1:0] out_data
);
	import mem_geom_pkg::*;

	logic [HALF_WIDTH-1:0] low_q;
	logic                  pair_hi;  // low half held, next half completes the pair
	logic                  half_take;
	logic                  out_take;

	// --------------------
	// Handshakes
	// --------------------

	// Output register empty or leaving this cycle
	assign half_ready = !out_valid || out_ready;

	assign half_take = half_valid && half_ready;
	assign out_take = out_valid && out_ready;

	// --------------------
	// Pair state
	// --------------------

	always_ff @(posedge clk2x) begin
		if (rst || flush) begin
			pair_hi <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (half_take) begin
				pair_hi <= !pair_hi;
			end
			// New pair replaces an accepted one without a gap
			if (half_take && pair_hi) begin
				out_valid <= 1'b1;
			end else if (out_take) begin
				out_valid <= 1'b0;
			end
		end
	end

	// --------------------
	// Payload
	// --------------------

	always_ff @(posedge clk2x) begin
		if (half_take && !pair_hi) begin
			low_q <= half_data;
		end
		// High half lands above the stored low half
		if (half_take && pair_hi) begin
			out_data <= {half_data, low_q};
		end
	end

endmodule

// File: src/pumped_memstream.sv
`timescale 1ns/1ps

module pumped_memstream (
	input  logic                                 clk2x,
	input  logic                                 rst,

	// Configuration port, four-phase
	input  logic                                 cfg_req,
	input  logic                                 cfg_we,
	input  logic [mem_geom_pkg::WORD_ADDR_WIDTH-1:0] cfg_addr,
	input  logic [mem_geom_pkg::WORD_WIDTH-1:0]  cfg_wdata,
	output logic                                 cfg_ack,
	output logic [mem_geom_pkg::WORD_WIDTH-1:0]  cfg_rdata,

	// Stream control and output
	input  logic                                 enable,
	input  logic                                 out_ready,
	output logic                                 out_valid,
	output logic [mem_geom_pkg::WORD_WIDTH-1:0]  out_data
);
	import mem_geom_pkg::*;

	// Half-word stream between streamer and assembler
	logic                  half_valid;
	logic                  half_ready;
	logic [HALF_WIDTH-1:0] half_data;
	logic                  flush;

	// Config to memory requests
	half_mem_if mem_bus ();

	// --------------------
	// Blocks
	// --------------------

	cfg_pump_adapter u_adapter (
		.clk2x     (clk2x),
		.rst       (rst),
		.cfg_req   (cfg_req),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_ack   (cfg_ack),
		.cfg_rdata (cfg_rdata),
		.mem       (mem_bus.requester)
	);

	half_word_streamer u_streamer (
		.clk2x      (clk2x),
		.rst        (rst),
		.enable     (enable),
		.half_ready (half_ready),
		.half_valid (half_valid),
		.half_data  (half_data),
		.flush      (flush),
		.mem        (mem_bus.memory)
	);

	// Joins half pairs back into full words
	word_pair_assembler u_assembler (
		.clk2x      (clk2x),
		.rst        (rst),
		.flush      (flush),
		.half_valid (half_valid),
		.half_data  (half_data),
		.out_ready  (out_ready),
		.half_ready (half_ready),
		.out_valid  (out_valid),
		.out_data   (out_data)
	);

endmodule

// File: test/pumped_memstream_assertions.sv
`timescale 1ns/1ps

module pumped_memstream_assertions (
	input logic                                clk2x,
	input logic                                rst,
	input logic                                cfg_req,
	input logic                                cfg_ack,
	input logic                                enable,
	input logic                                out_ready,
	input logic                                out_valid,
	input logic [mem_geom_pkg::WORD_WIDTH-1:0] out_data
);

	// Failed properties so far, read by the testbench
	int unsigned failures = 0;

	// --------------------
	// Configuration port
	// --------------------

	// Ack only answers a request that was already up
	ack_rise_after_req: assert property (@(posedge clk2x) disable iff (rst)
		$rose(cfg_ack) |-> $past(cfg_req))
	else begin
		failures++;
		$error("cfg_ack rose without cfg_req");
	end

	// Return to zero, ack drops only once req is seen low
	ack_fall_after_req: assert property (@(posedge clk2x) disable iff (rst)
		$fell(cfg_ack) |-> !$past(cfg_req))
	else begin
		failures++;
		$error("cfg_ack fell while cfg_req was high");
	end

	// --------------------
	// Output stream
	// --------------------

	// Held word stays put, only a flush may drop it
	out_held_stable: assert property (@(posedge clk2x) disable iff (rst)
		(out_valid && !out_ready) |=> (!enable || (out_valid && $stable(out_data))))
	else begin
		failures++;
		$error("out_valid or out_data changed before out_ready");
	end

	// Quiet outputs out of reset
	quiet_in_reset: assert property (@(posedge clk2x)
		$past(rst) |-> (!cfg_ack && !out_valid))
	else begin
		failures++;
		$error("cfg_ack or out_valid high during reset");
	end

endmodule

// File: test/pumped_memstream_tb.sv
`timescale 1ns/1ps

module pumped_memstream_tb;
	import mem_geom_pkg::*;

	localparam logic [31:0] LCG_SEED = 32'd97858;
	localparam int ACK_TIMEOUT = 50;
	localparam int WORD_TIMEOUT = 40;

	// DUT inputs start at known levels
	logic                       clk2x = 1'b0;
	logic                       rst = 1'b1;
	logic                       cfg_req = 1'b0;
	logic                       cfg_we = 1'b0;
	logic [WORD_ADDR_WIDTH-1:0] cfg_addr = '0;
	logic [WORD_WIDTH-1:0]      cfg_wdata = '0;
	logic                       enable = 1'b0;
	logic                       out_ready = 1'b0;
	logic                       cfg_ack;
	logic [WORD_WIDTH-1:0]      cfg_rdata;
	logic                       out_valid;
	logic [WORD_WIDTH-1:0]      out_data;

	// Reference memory and stream position
	logic [WORD_WIDTH-1:0]      model [WORD_DEPTH];
	logic [31:0]                data_lcg = LCG_SEED;
	logic [31:0]                ready_lcg = LCG_SEED;
	logic [WORD_ADDR_WIDTH-1:0] stream_idx = '0;  // wraps modulo WORD_DEPTH
	int unsigned                accepted = 0;
	logic                       ready_random = 1'b0;
	// A word rewritten mid-stream may still show old halves for a while
	logic                       old_ok = 1'b0;
	logic [WORD_ADDR_WIDTH-1:0] old_addr = '0;
	logic [WORD_WIDTH-1:0]      old_data = '0;

	pumped_memstream UUT (
		.clk2x(clk2x), .rst(rst),
		.cfg_req(cfg_req), .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.cfg_ack(cfg_ack), .cfg_rdata(cfg_rdata),
		.enable(enable), .out_ready(out_ready), .out_valid(out_valid), .out_data(out_data)
	);

	bind pumped_memstream pumped_memstream_assertions u_protocol_chk (
		.clk2x(clk2x), .rst(rst), .cfg_req(cfg_req), .cfg_ack(cfg_ack), .enable(enable),
		.out_ready(out_ready), .out_valid(out_valid), .out_data(out_data)
	);

	// 20 ns period
	always #10 clk2x = ~clk2x;

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Halves are written separately, so each may be old or new on its own
	function automatic logic halves_old_or_new(input logic [WORD_WIDTH-1:0] word,
		input logic [WORD_WIDTH-1:0] old_word, input logic [WORD_WIDTH-1:0] new_word);
		logic lo_ok;
		logic hi_ok;
		lo_ok = (word[HALF_WIDTH-1:0] == old_word[HALF_WIDTH-1:0]) ||
			(word[HALF_WIDTH-1:0] == new_word[HALF_WIDTH-1:0]);
		hi_ok = (word[WORD_WIDTH-1:HALF_WIDTH] == old_word[WORD_WIDTH-1:HALF_WIDTH]) ||
			(word[WORD_WIDTH-1:HALF_WIDTH] == new_word[WORD_WIDTH-1:HALF_WIDTH]);
		return lo_ok && hi_ok;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	// --------------------
	// Output monitor
	// --------------------

	// Ready driven and transfer judged mid-cycle, where out_valid is stable
	always @(negedge clk2x) begin
		ready_lcg = lcg_step(ready_lcg);
		out_ready = ready_random ? (ready_lcg[20:18] > 3'd2) : 1'b1;
		if (out_valid && out_ready) begin
			assert (out_data == model[stream_idx] ||
				(old_ok && stream_idx == old_addr &&
				halves_old_or_new(out_data, old_data, model[old_addr])))
			else stop_run($sformatf("Mismatch out_data: got %h expected %h at word %h",
				out_data, model[stream_idx], stream_idx));
			stream_idx = stream_idx + WORD_ADDR_WIDTH'(1);
			accepted++;
		end
	end

	// First bound property failure ends the run
	always @(negedge clk2x) begin
		assert (UUT.u_protocol_chk.failures == 0)
		else stop_run("Protocol assertion failed on the top-level ports");
	end

	// --------------------
	// Host side
	// --------------------

	task automatic wait_ack(input logic level);
		for (int n = 0; n < ACK_TIMEOUT; n++) begin
			@(negedge clk2x);
			if (cfg_ack == level) begin
				break;
			end
		end
		if (cfg_ack != level) begin
			stop_run($sformatf("Timeout waiting for cfg_ack to go %0b", level));
		end
	endtask

	// One full four-phase cycle
	task automatic cfg_access(input logic we, input logic [WORD_ADDR_WIDTH-1:0] addr,
		input logic [WORD_WIDTH-1:0] wdata, output logic [WORD_WIDTH-1:0] rdata);
		@(negedge clk2x);
		cfg_we = we;
		cfg_addr = addr;
		cfg_wdata = wdata;
		cfg_req = 1'b1;
		wait_ack(1'b1);
		// Read data only counts while ack is up
		rdata = cfg_rdata;
		cfg_req = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic check_read(input logic [WORD_ADDR_WIDTH-1:0] addr);
		logic [WORD_WIDTH-1:0] got;
		cfg_access(1'b0, addr, '0, got);
		assert (got == model[addr])
		else stop_run($sformatf("Mismatch cfg_rdata: got %h expected %h at word %h",
			got, model[addr], addr));
	endtask

	// Returns on a rising edge, clear of the monitor
	task automatic wait_words(input int unsigned count);
		int unsigned target;
		@(posedge clk2x);
		target = accepted + count;
		for (int unsigned n = 0; n < count * WORD_TIMEOUT; n++) begin
			@(posedge clk2x);
			if (accepted >= target) begin
				break;
			end
		end
		if (accepted < target) begin
			stop_run($sformatf("Timeout waiting for %0d stream words", count));
		end
	endtask

	initial begin
		logic [WORD_WIDTH-1:0]      scratch;
		logic [WORD_ADDR_WIDTH-1:0] addr;
		repeat (4) @(posedge clk2x);
		@(negedge clk2x);
		rst = 1'b0;

		// Fill with the stream off, then read everything back
		for (int i = 0; i < WORD_DEPTH; i++) begin
			addr = WORD_ADDR_WIDTH'(i);
			data_lcg = lcg_step(data_lcg);
			model[addr] = data_lcg[31:16];
			cfg_access(1'b1, addr, model[addr], scratch);
		end
		for (int i = 0; i < WORD_DEPTH; i++) begin
			check_read(WORD_ADDR_WIDTH'(i));
		end

		// Free-running stream over two wraps
		@(negedge clk2x);
		enable = 1'b1;
		wait_words(2 * WORD_DEPTH + 3);

		// Back-pressure from the LCG
		ready_random = 1'b1;
		wait_words(2 * WORD_DEPTH);

		// Config reads racing the stream
		for (int i = 0; i < 4; i++) begin
			data_lcg = lcg_step(data_lcg);
			check_read(data_lcg[16 +: WORD_ADDR_WIDTH]);
		end

		// Restart, must come back at word 0
		@(negedge clk2x);
		enable = 1'b0;
		repeat (4) @(posedge clk2x);
		stream_idx = '0;
		@(negedge clk2x);
		enable = 1'b1;
		wait_words(WORD_DEPTH + 5);

		// Rewrite one word mid-stream
		data_lcg = lcg_step(data_lcg);
		addr = data_lcg[16 +: WORD_ADDR_WIDTH];
		old_addr = addr;
		old_data = model[addr];
		old_ok = 1'b1;
		model[addr] = ~old_data;
		cfg_access(1'b1, addr, model[addr], scratch);
		wait_words(2 * WORD_DEPTH);
		// From here only the new value is allowed
		old_ok = 1'b0;
		wait_words(WORD_DEPTH + 1);

		@(negedge clk2x);
		enable = 1'b0;
		repeat (2) @(posedge clk2x);
		if (UUT.u_protocol_chk.failures == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			stop_run("Protocol assertions failed during the run");
		end
	end

endmodule

// File: pumped_memstream.f
src/mem_geom_pkg.sv
src/mem_ctrl_pkg.sv
src/half_mem_if.sv
src/cfg_pump_adapter.sv
src/half_word_streamer.sv
src/word_pair_assembler.sv
src/pumped_memstream.sv
test/pumped_memstream_assertions.sv
test/pumped_memstream_tb.sv

// File: Makefile
TOP = pumped_memstream_tb

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f pumped_memstream.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "TESTS PASSED" > /dev/null

clean:
	rm -rf obj_dir
